// ==== tcb_lite_pkg.sv ====
package tcb_lite_pkg;

    ////////////////////////////////////////////////////////////
    // bus geometry
    ////////////////////////////////////////////////////////////

    // byte address, full 32-bit space
    localparam int unsigned ADR_W = 32;
    // whole words only, no byte enables
    localparam int unsigned DAT_W = 32;

    ////////////////////////////////////////////////////////////
    // transfer encoding
    ////////////////////////////////////////////////////////////

    // carried on the bus as the single wen bit
    typedef enum logic {
        TCB_READ  = 1'b0,
        TCB_WRITE = 1'b1
    } tcb_op_e;

    ////////////////////////////////////////////////////////////
    // handshake timing
    ////////////////////////////////////////////////////////////

    // cycles from the transfer cycle to rdt/err
    // no ready, subordinates never stall
    localparam int unsigned RSP_DLY = 1;

endpackage: tcb_lite_pkg

// ==== gpio_map_pkg.sv ====
package gpio_map_pkg;

    ////////////////////////////////////////////////////////////
    // controller array
    ////////////////////////////////////////////////////////////

    // identical GPIO controllers on the peripheral bus
    localparam int unsigned GPIO_N = 4;
    // pins per controller
    localparam int unsigned GDW    = 8;
    // port index width
    localparam int unsigned PORT_W = $clog2(GPIO_N);

    ////////////////////////////////////////////////////////////
    // address map
    ////////////////////////////////////////////////////////////

    // bytes per controller, port index starts at bit 6
    localparam int unsigned PORT_SPAN = 64;
    // first address past the last controller
    localparam int unsigned MAP_LIMIT = GPIO_N * PORT_SPAN;

    // register offsets inside one controller block
    typedef enum logic [$clog2(PORT_SPAN)-1:0] {
        // output data
        REG_OUT = 6'h00,
        // output enable
        REG_ENA = 6'h04,
        // synchronized pin input, read only
        REG_IN  = 6'h08
    } gpio_reg_e;

endpackage: gpio_map_pkg

// ==== tcb_peri_decoder.sv ====
module tcb_peri_decoder (
    // manager request
    input  logic                              tcb_vld,
    input  logic [tcb_lite_pkg::ADR_W-1:0]    tcb_adr,
    // one-hot request per controller
    output logic [gpio_map_pkg::GPIO_N-1:0]   per_vld,
    // port index for the response path
    output logic [gpio_map_pkg::PORT_W-1:0]   dec_sel,
    // valid transfer to an unmapped address
    output logic                              dec_err
);

    import tcb_lite_pkg::*;
    import gpio_map_pkg::*;

    // address falls outside all controller blocks
    logic unmapped;

    ////////////////////////////////////////////////////////////
    // address compare
    ////////////////////////////////////////////////////////////

    // everything from MAP_LIMIT upwards has no subordinate
    assign unmapped = (tcb_adr >= ADR_W'(MAP_LIMIT));

    // only a real transfer reports a decode error
    assign dec_err = tcb_vld & unmapped;

    ////////////////////////////////////////////////////////////
    // port select
    ////////////////////////////////////////////////////////////

    // port index sits right above the per-port offset
    assign dec_sel = tcb_adr[$clog2(PORT_SPAN) +: PORT_W];

    // one-hot request, none at all on a decode error
    always_comb begin
        per_vld = '0;
        if (tcb_vld && !unmapped) begin
            per_vld[dec_sel] = 1'b1;
        end
    end

endmodule: tcb_peri_decoder

// ==== tcb_peri_gpio.sv ====
module tcb_peri_gpio (
    // system
    input  logic                                    clk,
    input  logic                                    arst_n,
    // request from the decoder
    input  logic                                    vld,
    input  logic                                    wen,
    input  logic [$clog2(gpio_map_pkg::PORT_SPAN)-1:0] adr,
    input  logic [tcb_lite_pkg::DAT_W-1:0]          wdt,
    // registered response
    output logic [tcb_lite_pkg::DAT_W-1:0]          rdt,
    output logic                                    err,
    // pins
    output logic [gpio_map_pkg::GDW-1:0]            gpio_o,
    output logic [gpio_map_pkg::GDW-1:0]            gpio_e,
    input  logic [gpio_map_pkg::GDW-1:0]            gpio_i
);

    import tcb_lite_pkg::*;
    import gpio_map_pkg::*;

    // decoded transfer direction
    tcb_op_e          op;
    // offset names one of the three registers
    logic             reg_known;
    // read value of the addressed register
    logic [DAT_W-1:0] reg_rdt;
    // two-flop input synchronizer
    logic [GDW-1:0]   gpio_s1;
    logic [GDW-1:0]   gpio_s2;

    assign op = tcb_op_e'(wen);

    ////////////////////////////////////////////////////////////
    // input synchronizer
    ////////////////////////////////////////////////////////////

    // pins are asynchronous to clk
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            gpio_s1 <= '0;
            gpio_s2 <= '0;
        end else begin
            gpio_s1 <= gpio_i;
            gpio_s2 <= gpio_s1;
        end
    end

    ////////////////////////////////////////////////////////////
    // register file
    ////////////////////////////////////////////////////////////

    // read mux, zero-extended to the bus width
    always_comb begin
        reg_known = 1'b1;
        reg_rdt   = '0;
        case (adr)
            REG_OUT: reg_rdt = DAT_W'(gpio_o);
            REG_ENA: reg_rdt = DAT_W'(gpio_e);
            REG_IN:  reg_rdt = DAT_W'(gpio_s2);
            // misaligned or unused offsets
            default: reg_known = 1'b0;
        endcase
    end

    // output and enable drive the pins directly
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            gpio_o <= '0;
            gpio_e <= '0;
        end else if (vld && op == TCB_WRITE) begin
            case (adr)
                REG_OUT: gpio_o <= wdt[GDW-1:0];
                REG_ENA: gpio_e <= wdt[GDW-1:0];
                // REG_IN is read only, write dropped silently
                default: begin
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // response
    ////////////////////////////////////////////////////////////

    // one cycle after the request, zero when idle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rdt <= '0;
            err <= 1'b0;
        end else begin
            rdt <= (vld && op == TCB_READ) ? reg_rdt : '0;
            err <= vld & ~reg_known;
        end
    end

endmodule: tcb_peri_gpio

// ==== tcb_peri_rsp_mux.sv ====
module tcb_peri_rsp_mux (
    // system
    input  logic                                                  clk,
    input  logic                                                  arst_n,
    // request side
    input  logic                                                  tcb_vld,
    input  logic [gpio_map_pkg::PORT_W-1:0]                       dec_sel,
    input  logic                                                  dec_err,
    // per controller responses, already registered
    input  logic [gpio_map_pkg::GPIO_N-1:0][tcb_lite_pkg::DAT_W-1:0] per_rdt,
    input  logic [gpio_map_pkg::GPIO_N-1:0]                       per_err,
    // manager response
    output logic [tcb_lite_pkg::DAT_W-1:0]                        tcb_rdt,
    output logic                                                  tcb_err
);

    import tcb_lite_pkg::*;
    import gpio_map_pkg::*;

    // port index of the transfer now in its response cycle
    logic [PORT_W-1:0] sel_q;
    // decode error of that transfer
    logic              err_q;

    // capture routing info alongside the request
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sel_q <= '0;
            err_q <= 1'b0;
        end else begin
            if (tcb_vld) begin
                sel_q <= dec_sel;
            end
            err_q <= dec_err;
        end
    end

    // idle controllers return zeros, so a stale sel_q is harmless
    // decode error wins over any controller data
    assign tcb_rdt = err_q ? DAT_W'(0) : per_rdt[sel_q];
    assign tcb_err = err_q | per_err[sel_q];

endmodule: tcb_peri_rsp_mux

// ==== gpio_subsys_top.sv ====
module gpio_subsys_top (
    // system
    input  logic                                                clk,
    input  logic                                                arst_n,
    // TCB-lite manager side
    input  logic                                                tcb_vld,
    input  logic                                                tcb_wen,
    input  logic [tcb_lite_pkg::ADR_W-1:0]                      tcb_adr,
    input  logic [tcb_lite_pkg::DAT_W-1:0]                      tcb_wdt,
    output logic [tcb_lite_pkg::DAT_W-1:0]                      tcb_rdt,
    output logic                                                tcb_err,
    // pins, port i in slice [i*GDW +: GDW]
    output logic [gpio_map_pkg::GPIO_N*gpio_map_pkg::GDW-1:0]   gpio_o,
    output logic [gpio_map_pkg::GPIO_N*gpio_map_pkg::GDW-1:0]   gpio_e,
    input  logic [gpio_map_pkg::GPIO_N*gpio_map_pkg::GDW-1:0]   gpio_i
);

    import tcb_lite_pkg::*;
    import gpio_map_pkg::*;

    // decoder outputs
    logic [GPIO_N-1:0]            per_vld;
    logic [PORT_W-1:0]            dec_sel;
    logic                         dec_err;
    // controller responses
    logic [GPIO_N-1:0][DAT_W-1:0] per_rdt;
    logic [GPIO_N-1:0]            per_err;

    ////////////////////////////////////////////////////////////
    // address decoder
    ////////////////////////////////////////////////////////////

    tcb_peri_decoder dec (
        .tcb_vld (tcb_vld),
        .tcb_adr (tcb_adr),
        .per_vld (per_vld),
        .dec_sel (dec_sel),
        .dec_err (dec_err)
    );

    ////////////////////////////////////////////////////////////
    // GPIO controllers
    ////////////////////////////////////////////////////////////

    // offset and write data shared by all ports
    for (genvar i = 0; i < GPIO_N; i++) begin: gpio_gen
        tcb_peri_gpio gpio (
            .clk    (clk),
            .arst_n (arst_n),
            .vld    (per_vld[i]),
            .wen    (tcb_wen),
            .adr    (tcb_adr[$clog2(PORT_SPAN)-1:0]),
            .wdt    (tcb_wdt),
            .rdt    (per_rdt[i]),
            .err    (per_err[i]),
            .gpio_o (gpio_o[i*GDW +: GDW]),
            .gpio_e (gpio_e[i*GDW +: GDW]),
            .gpio_i (gpio_i[i*GDW +: GDW])
        );
    end: gpio_gen

    ////////////////////////////////////////////////////////////
    // response path
    ////////////////////////////////////////////////////////////

    tcb_peri_rsp_mux rsp (
        .clk     (clk),
        .arst_n  (arst_n),
        .tcb_vld (tcb_vld),
        .dec_sel (dec_sel),
        .dec_err (dec_err),
        .per_rdt (per_rdt),
        .per_err (per_err),
        .tcb_rdt (tcb_rdt),
        .tcb_err (tcb_err)
    );

endmodule: gpio_subsys_top

// ==== tb_gpio_subsys.sv ====
module tb_gpio_subsys;

    import tcb_lite_pkg::*;
    import gpio_map_pkg::*;

    // test lengths
    localparam int N_RAND = 300;
    localparam int N_PIN  = 6;
    localparam int N_ERR  = 40;
    // reset reads + random + pin rounds + error cases + final readback
    localparam int N_XFER = 2*GPIO_N + N_RAND + N_PIN*GPIO_N*3 + N_ERR + 2*GPIO_N;
    localparam int CYCLE_LIMIT = 2*N_XFER + 100;
    localparam int OFF_W = $clog2(PORT_SPAN);

    // one issued transfer with its expected response
    typedef struct packed {
        logic             wen;
        logic [ADR_W-1:0] adr;
        logic [DAT_W-1:0] wdt;
        logic             err;
        logic [DAT_W-1:0] rdt;
    } xfer_t;

    logic                  clk;
    logic                  arst_n;
    logic                  tcb_vld;
    logic                  tcb_wen;
    logic [ADR_W-1:0]      tcb_adr;
    logic [DAT_W-1:0]      tcb_wdt;
    logic [DAT_W-1:0]      tcb_rdt;
    logic                  tcb_err;
    logic [GPIO_N*GDW-1:0] gpio_o;
    logic [GPIO_N*GDW-1:0] gpio_e;
    logic [GPIO_N*GDW-1:0] gpio_i;

    // model copy 0 at issue time, copy 1 follows the pins
    logic [GDW-1:0] mdl_out [2][GPIO_N];
    logic [GDW-1:0] mdl_ena [2][GPIO_N];
    // pin values currently held on gpio_i
    logic [GDW-1:0] pin_hold [GPIO_N];
    xfer_t          exp_q [$];
    xfer_t          rsp_x;
    // transfer history, top bit is the one now answering
    logic [RSP_DLY:0] pend;
    int             cycles;
    logic [31:0]    rnd;

    gpio_subsys_top i_gpio_subsys_top (
        .clk     (clk),
        .arst_n  (arst_n),
        .tcb_vld (tcb_vld),
        .tcb_wen (tcb_wen),
        .tcb_adr (tcb_adr),
        .tcb_wdt (tcb_wdt),
        .tcb_rdt (tcb_rdt),
        .tcb_err (tcb_err),
        .gpio_o  (gpio_o),
        .gpio_e  (gpio_e),
        .gpio_i  (gpio_i)
    );

    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [ADR_W-1:0] port_adr(input int unsigned p,
                                                  input logic [OFF_W-1:0] off);
        return ADR_W'(p * PORT_SPAN) + ADR_W'(off);
    endfunction

    // expected {err, rdt} for a transfer
    function automatic logic [DAT_W:0] ref_read(input logic wen, input logic [ADR_W-1:0] adr);
        logic [PORT_W-1:0] port;
        logic [GDW-1:0]    val;
        port = adr[OFF_W +: PORT_W];
        val  = '0;
        // nothing mapped past the last port
        if (adr >= ADR_W'(MAP_LIMIT)) begin
            return {1'b1, DAT_W'(0)};
        end
        case (adr[OFF_W-1:0])
            6'h00: val = mdl_out[0][port];
            6'h04: val = mdl_ena[0][port];
            6'h08: val = pin_hold[port];
            default: return {1'b1, DAT_W'(0)};
        endcase
        // writes return no data, REG_IN write is silently dropped
        if (wen) begin
            return '0;
        end
        return {1'b0, DAT_W'(val)};
    endfunction

    // only REG_OUT and REG_ENA of a mapped port hold state
    task automatic apply_write(input int cp, input logic [ADR_W-1:0] adr,
                               input logic [DAT_W-1:0] wdt);
        logic [PORT_W-1:0] port;
        port = adr[OFF_W +: PORT_W];
        if (adr < ADR_W'(MAP_LIMIT)) begin
            if (adr[OFF_W-1:0] == 6'h00) begin
                mdl_out[cp][port] = wdt[GDW-1:0];
            end else if (adr[OFF_W-1:0] == 6'h04) begin
                mdl_ena[cp][port] = wdt[GDW-1:0];
            end
        end
    endtask

    task automatic check(input string what, input logic [DAT_W-1:0] got,
                         input logic [DAT_W-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] t=%0t %s: got 0x%08h, expected 0x%08h", $time, what, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch on %s", what);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // bus driver
    ////////////////////////////////////////////////////////////

    task automatic step_rand;
        rnd = xorshift32(rnd);
    endtask

    // one transfer cycle, expected response queued in issue order
    task automatic issue(input logic wen, input logic [ADR_W-1:0] adr,
                         input logic [DAT_W-1:0] wdt);
        xfer_t x;
        logic [DAT_W:0] e;
        @(posedge clk);
        tcb_vld <= 1'b1;
        tcb_wen <= wen;
        tcb_adr <= adr;
        tcb_wdt <= wdt;
        e = ref_read(wen, adr);
        x.wen = wen;
        x.adr = adr;
        x.wdt = wdt;
        x.err = e[DAT_W];
        x.rdt = e[DAT_W-1:0];
        exp_q.push_back(x);
        if (wen) begin
            apply_write(0, adr, wdt);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            tcb_vld <= 1'b0;
        end
    endtask

    // new pin values, then enough idle time for the synchronizer
    task automatic set_pins(input logic [GPIO_N*GDW-1:0] val);
        @(posedge clk);
        tcb_vld <= 1'b0;
        gpio_i  <= val;
        for (int p = 0; p < GPIO_N; p++) begin
            pin_hold[p] = val[p*GDW +: GDW];
        end
        idle(4);
    endtask

    ////////////////////////////////////////////////////////////
    // compare and timeout
    ////////////////////////////////////////////////////////////

    // negedge, mid-cycle, response and pins are settled
    always @(negedge clk) begin
        pend = {pend[RSP_DLY-1:0], tcb_vld & arst_n};
        if (pend[RSP_DLY]) begin
            rsp_x = exp_q.pop_front();
            check("tcb_err", DAT_W'(tcb_err), DAT_W'(rsp_x.err));
            check("tcb_rdt", tcb_rdt, rsp_x.rdt);
            // pins move in the response cycle
            if (rsp_x.wen) begin
                apply_write(1, rsp_x.adr, rsp_x.wdt);
            end
        end
        for (int p = 0; p < GPIO_N; p++) begin
            check($sformatf("gpio_o port %0d", p), DAT_W'(gpio_o[p*GDW +: GDW]),
                  DAT_W'(mdl_out[1][p]));
            check($sformatf("gpio_e port %0d", p), DAT_W'(gpio_e[p*GDW +: GDW]),
                  DAT_W'(mdl_ena[1][p]));
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run hung after %0d cycles", cycles);
            $display("TESTBENCH FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        logic [31:0]      a;
        logic [ADR_W-1:0] adr;
        logic [OFF_W-1:0] off;
        clk     = 1'b0;
        arst_n  = 1'b0;
        tcb_vld = 1'b0;
        tcb_wen = 1'b0;
        tcb_adr = '0;
        tcb_wdt = '0;
        gpio_i  = '0;
        rnd     = 32'hdf60_be71;
        pend    = '0;
        cycles  = 0;
        for (int p = 0; p < GPIO_N; p++) begin
            mdl_out[0][p] = '0;
            mdl_out[1][p] = '0;
            mdl_ena[0][p] = '0;
            mdl_ena[1][p] = '0;
            pin_hold[p]   = '0;
        end
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;

        // reset values on every port
        for (int p = 0; p < GPIO_N; p++) begin
            issue(1'b0, port_adr(p, 6'h00), '0);
            issue(1'b0, port_adr(p, 6'h04), '0);
        end

        // random back-to-back traffic on out and ena
        repeat (N_RAND) begin
            step_rand;
            a = rnd;
            step_rand;
            issue(a[0], port_adr(32'(a[2:1]), a[3] ? 6'h04 : 6'h00), rnd);
            if (a[7:4] == 4'h0) begin
                idle(1);
            end
        end

        // pin input path, REG_IN writes ignored
        repeat (N_PIN) begin
            step_rand;
            set_pins(rnd);
            for (int p = 0; p < GPIO_N; p++) begin
                issue(1'b0, port_adr(p, 6'h08), '0);
                step_rand;
                issue(1'b1, port_adr(p, 6'h08), rnd);
                issue(1'b0, port_adr(p, 6'h08), '0);
            end
        end

        // unmapped addresses and unknown offsets
        repeat (N_ERR) begin
            step_rand;
            a = rnd;
            step_rand;
            if (a[0]) begin
                adr = (rnd < ADR_W'(MAP_LIMIT)) ? (rnd | 32'h100) : rnd;
            end else begin
                off = a[9:4];
                if (off == 6'h00 || off == 6'h04 || off == 6'h08) begin
                    off = off | 6'h01;
                end
                adr = port_adr(32'(a[2:1]), off);
            end
            issue(a[3], adr, rnd);
        end

        // state must have survived the error traffic
        for (int p = 0; p < GPIO_N; p++) begin
            issue(1'b0, port_adr(p, 6'h00), '0);
            issue(1'b0, port_adr(p, 6'h04), '0);
        end
        idle(RSP_DLY + 2);

        if (exp_q.size() != 0) begin
            $display("run ended with %0d responses never checked", exp_q.size());
            $display("TESTBENCH FAILED");
            $fatal(1, "responses missing");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule: tb_gpio_subsys

// ==== gpio_subsys.f ====
tcb_lite_pkg.sv
gpio_map_pkg.sv
tcb_peri_decoder.sv
tcb_peri_gpio.sv
tcb_peri_rsp_mux.sv
gpio_subsys_top.sv
tb_gpio_subsys.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the GPIO subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -f sim.log

verilator --binary --timing \
    --top-module tb_gpio_subsys \
    -f gpio_subsys.f \
    -o sim_gpio_subsys

./obj_dir/sim_gpio_subsys | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
    echo "simulation ended without a result, see sim.log"
    exit 1
fi
echo "simulation passed"
